// ==== include/sme_defs.svh ====
`ifndef SME_DEFS_SVH
`define SME_DEFS_SVH

// Beat geometry, one lane per byte position
`define SME_BEAT_BYTES 8
`define SME_PAT_LEN    3
`define SME_HIST_BYTES 7

// Fast pattern table, earliest byte sits in the low byte
`define SME_NUM_PATS 4
`define SME_PAT0     24'h434241
`define SME_PAT1     24'h424143
`define SME_PAT2     24'h414444
`define SME_PAT3     24'h444142

// Rule ids reported on a hit, zero is reserved for no hit
`define SME_ID0      16'd1
`define SME_ID1      16'd2
`define SME_ID2      16'd3
`define SME_ID3      16'd4

// Result FIFO entries
`define SME_FIFO_DEPTH 4

`endif

// ==== logic/lane_bus_if.sv ====
`timescale 1ns/1ps

interface lane_bus_if import sme_pkg::*; ();

  // Feeder to lanes
  logic [7:0][23:0] win_bytes;
  logic [7:0]       win_ok;
  logic             beat_stb;

  // Lanes to result path, each lane owns one slot
  rule_id_t         lane_id [8];
  logic             res_stb;

  modport feeder (
    output win_bytes,
    output win_ok,
    output beat_stb
  );

  modport lane (
    input  win_bytes,
    input  win_ok,
    input  beat_stb,
    output lane_id,
    output res_stb
  );

  modport sink (
    input lane_id,
    input res_stb
  );

endinterface

// ==== logic/match_collector.sv ====
`timescale 1ns/1ps

module match_collector import sme_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  logic         reload,
  input  logic         res_valid,
  input  beat_result_t res,
  output logic         res_ready,
  input  logic         next_index,
  output rule_id_t     match_index,
  output logic         match_valid,
  output logic [7:0]   match_valid_stat
);

  coll_state_t  state;
  beat_result_t cur;
  logic [7:0]   mask;
  logic [7:0]   res_mask;
  logic [7:0]   mask_next;
  logic [2:0]   sel;

  //////////////////////////////
  // Lane selection
  //////////////////////////////

  always_comb begin
    for (int k = 0; k < 8; k++) begin
      res_mask[k] = (res.id[k] != '0);
    end
  end

  // Lowest unconsumed lane wins
  always_comb begin
    sel = '0;
    for (int k = 7; k >= 0; k--) begin
      if (mask[k]) sel = 3'(k);
    end
  end

  assign mask_next = mask & ~(8'd1 << sel);

  assign res_ready        = (state == COLL_EMPTY);
  assign match_valid      = (state == COLL_PRESENT);
  assign match_valid_stat = mask;
  assign match_index      = cur.id[sel];

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst || reload) begin
      state <= COLL_EMPTY;
      mask  <= '0;
    end else begin
      case (state)
        COLL_EMPTY: begin
          // FIFO only holds beats with a hit, so the mask is never zero here
          if (res_valid) begin
            state <= COLL_PRESENT;
            mask  <= res_mask;
          end
        end
        COLL_PRESENT: begin
          if (next_index) begin
            mask <= mask_next;
            if (mask_next == '0) state <= COLL_EMPTY;
          end
        end
        default: state <= COLL_EMPTY;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (res_valid && res_ready) cur <= res;
  end

  a_no_zero_id: assert property (@(posedge clk) disable iff (rst)
    match_valid |-> (match_index != '0));

endmodule

// ==== logic/match_fifo.sv ====
`timescale 1ns/1ps
`include "sme_defs.svh"

module match_fifo import sme_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  logic         clear,
  input  logic         din_valid,
  input  beat_result_t din,
  output logic         dout_valid,
  output beat_result_t dout,
  input  logic         dout_ready,
  output logic         almost_full
);

  localparam int DEPTH = `SME_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);
  localparam int CW    = $clog2(DEPTH + 1);

  beat_result_t  mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          full;
  logic          do_wr;
  logic          do_rd;

  assign full        = (count == CW'(DEPTH));
  assign almost_full = (count >= CW'(DEPTH - 1));
  assign dout_valid  = (count != '0);
  assign dout        = mem[rd_ptr];

  assign do_wr = din_valid && !full;
  assign do_rd = dout_valid && dout_ready;

  always_ff @(posedge clk) begin
    if (do_wr) mem[wr_ptr] <= din;
  end

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      // Simultaneous push and pop leaves the level alone
      if (do_wr && !do_rd) count <= count + 1'b1;
      else if (do_rd && !do_wr) count <= count - 1'b1;
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (rst || clear)
    !(din_valid && full));

endmodule

// ==== logic/pattern_lane.sv ====
`timescale 1ns/1ps
`include "sme_defs.svh"

module pattern_lane import sme_pkg::*; #(
  parameter int LANE = 0
) (
  input  logic     clk,
  input  logic     rst,
  lane_bus_if.lane lanes
);

  localparam int WIN_W = `SME_PAT_LEN * 8;
  localparam int NP    = `SME_NUM_PATS;

  localparam logic [WIN_W-1:0] PATS [NP] = '{`SME_PAT0, `SME_PAT1, `SME_PAT2, `SME_PAT3};
  localparam rule_id_t         IDS  [NP] = '{`SME_ID0, `SME_ID1, `SME_ID2, `SME_ID3};

  rule_id_t hit_id;

  // Table entries are distinct and at most one compare fires
  always_comb begin
    hit_id = '0;
    for (int p = 0; p < NP; p++) begin
      if (lanes.win_bytes[LANE] == PATS[p]) hit_id = IDS[p];
    end
    if (!lanes.win_ok[LANE]) hit_id = '0;
  end

  always_ff @(posedge clk) begin
    if (lanes.beat_stb) lanes.lane_id[LANE] <= hit_id;
  end

  // Lane 0 carries the strobe for the whole beat
  if (LANE == 0) begin : g_res_stb
    always_ff @(posedge clk) begin
      if (rst) lanes.res_stb <= 1'b0;
      else lanes.res_stb <= lanes.beat_stb;
    end
  end

  // A hit handed to the result path comes from a qualified window of the previous beat
  a_id_needs_ok: assert property (@(posedge clk) disable iff (rst)
    (lanes.res_stb && (lanes.lane_id[LANE] != '0))
      |-> $past(lanes.beat_stb && lanes.win_ok[LANE]));

endmodule

// ==== logic/sme_pkg.sv ====
package sme_pkg;

  //////////////////////////////
  // Result types
  //////////////////////////////

  // Zero means the lane saw no hit
  typedef logic [15:0] rule_id_t;

  // One id per lane, lane k in slot k
  typedef struct packed {
    rule_id_t [7:0] id;
  } beat_result_t;

  //////////////////////////////
  // Collector states
  //////////////////////////////

  typedef enum logic {
    COLL_EMPTY,
    COLL_PRESENT
  } coll_state_t;

endpackage

// ==== logic/sme_top.sv ====
`timescale 1ns/1ps

module sme_top import sme_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic [63:0] s_axis_tdata,
  input  logic [7:0]  s_axis_tkeep,
  input  logic        s_axis_tvalid,
  input  logic        s_axis_tlast,
  output logic        s_axis_tready,
  input  logic [63:0] preamble_state,
  input  logic        reload,
  input  logic        next_index,
  output logic [15:0] match_index,
  output logic        match_valid,
  output logic [7:0]  match_valid_stat,
  output logic [63:0] last_bytes_state
);

  localparam int NUM_LANES = $bits(beat_result_t) / $bits(rule_id_t);

  lane_bus_if   lanes ();
  beat_result_t lane_res;
  beat_result_t fifo_res;
  logic         fifo_almost_full;
  logic         fifo_valid;
  logic         fifo_ready;
  logic         fifo_wr;

  window_feeder u_feeder (
    .clk              (clk),
    .rst              (rst),
    .s_axis_tdata     (s_axis_tdata),
    .s_axis_tkeep     (s_axis_tkeep),
    .s_axis_tvalid    (s_axis_tvalid),
    .s_axis_tlast     (s_axis_tlast),
    .s_axis_tready    (s_axis_tready),
    .preamble_state   (preamble_state),
    .reload           (reload),
    .fifo_almost_full (fifo_almost_full),
    .last_bytes_state (last_bytes_state),
    .lanes            (lanes.feeder)
  );

  for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
    pattern_lane #(.LANE(k)) u_lane (
      .clk   (clk),
      .rst   (rst),
      .lanes (lanes.lane)
    );
  end

  //////////////////////////////
  // Result path
  //////////////////////////////

  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      lane_res.id[k] = lanes.lane_id[k];
    end
  end

  // Beats without any hit never reach the FIFO
  assign fifo_wr = lanes.res_stb && (lane_res != '0);

  match_fifo u_fifo (
    .clk         (clk),
    .rst         (rst),
    .clear       (reload),
    .din_valid   (fifo_wr),
    .din         (lane_res),
    .dout_valid  (fifo_valid),
    .dout        (fifo_res),
    .dout_ready  (fifo_ready),
    .almost_full (fifo_almost_full)
  );

  match_collector u_collector (
    .clk              (clk),
    .rst              (rst),
    .reload           (reload),
    .res_valid        (fifo_valid),
    .res              (fifo_res),
    .res_ready        (fifo_ready),
    .next_index       (next_index),
    .match_index      (match_index),
    .match_valid      (match_valid),
    .match_valid_stat (match_valid_stat)
  );

endmodule

// ==== logic/window_feeder.sv ====
`timescale 1ns/1ps
`include "sme_defs.svh"

module window_feeder import sme_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic [63:0] s_axis_tdata,
  input  logic [7:0]  s_axis_tkeep,
  input  logic        s_axis_tvalid,
  input  logic        s_axis_tlast,
  output logic        s_axis_tready,
  input  logic [63:0] preamble_state,
  input  logic        reload,
  input  logic        fifo_almost_full,
  output logic [63:0] last_bytes_state,
  lane_bus_if.feeder  lanes
);

  localparam int BB = `SME_BEAT_BYTES;
  localparam int HB = `SME_HIST_BYTES;
  localparam int WB = `SME_PAT_LEN;

  logic [HB*8-1:0]      hist_data;
  logic [3:0]           hist_len;
  logic                 run;
  logic                 beat;
  logic [3:0]           keep_cnt;
  logic [3:0]           len_sum;
  logic [3:0]           pre_len;
  logic [(HB+BB)*8-1:0] ext;

  //////////////////////////////
  // Handshake
  //////////////////////////////

  // Hold off while the FIFO has only the in-flight slot left
  assign s_axis_tready = run && !fifo_almost_full && !reload;
  assign beat          = s_axis_tvalid && s_axis_tready;
  assign lanes.beat_stb = beat;

  always_comb begin
    keep_cnt = '0;
    for (int i = 0; i < BB; i++) begin
      if (s_axis_tkeep[i]) keep_cnt = keep_cnt + 4'd1;
    end
  end

  //////////////////////////////
  // Windows
  //////////////////////////////

  // History bytes 0..6 with byte 6 newest followed by beat bytes 0..7
  assign ext = {s_axis_tdata, hist_data};

  always_comb begin
    for (int k = 0; k < BB; k++) begin
      lanes.win_bytes[k] = ext[(HB + k - WB + 1)*8 +: WB*8];
      lanes.win_ok[k]    = s_axis_tkeep[k] && (int'(hist_len) + k + 1 >= WB);
    end
  end

  //////////////////////////////
  // History
  //////////////////////////////

  assign len_sum = hist_len + keep_cnt;
  assign pre_len = (preamble_state[7:0] > 8'(HB)) ? 4'(HB) : preamble_state[3:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      run       <= 1'b0;
      hist_len  <= '0;
      hist_data <= '0;
    end else begin
      run <= 1'b1;
      if (reload) begin
        hist_data <= preamble_state[63:8];
        hist_len  <= pre_len;
      end else if (beat && s_axis_tlast) begin
        // Next packet must not see these bytes
        hist_data <= '0;
        hist_len  <= '0;
      end else if (beat) begin
        hist_data <= ext[keep_cnt*8 +: HB*8];
        hist_len  <= (len_sum > 4'(HB)) ? 4'(HB) : len_sum;
      end
    end
  end

  assign last_bytes_state = {hist_data, 4'd0, hist_len};

  a_keep_contig: assert property (@(posedge clk) disable iff (rst)
    beat |-> ((s_axis_tkeep & (s_axis_tkeep + 8'd1)) == 8'd0));

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f tb.f --top-module sme_tb -o sme_sim \
  && ./obj_dir/sme_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat sim.log
if grep -q "Result: FAILED" sim.log; then
  exit 1
fi
grep -q "Result: PASSED" sim.log || exit 1

// ==== sim/sme_tb.sv ====
`timescale 1ns/1ps
`include "sme_defs.svh"

module sme_tb import sme_pkg::*; ();

  localparam int RANDOM_BEATS   = 600;
  localparam int DIRECTED_BEATS = 40;
  localparam int CYCLE_LIMIT    = 20 * (RANDOM_BEATS + DIRECTED_BEATS) + 200;

  logic        clk;
  logic        rst;
  logic [63:0] s_axis_tdata;
  logic [7:0]  s_axis_tkeep;
  logic        s_axis_tvalid;
  logic        s_axis_tlast;
  logic        s_axis_tready;
  logic [63:0] preamble_state;
  logic        reload;
  logic        next_index;
  logic [15:0] match_index;
  logic        match_valid;
  logic [7:0]  match_valid_stat;
  logic [63:0] last_bytes_state;

  integer       seed = 32'h2342;
  int           cycle_count = 0;
  bit           hold_next;
  // Reference history with the newest byte at index 6
  logic [7:0]   hist [7];
  int           hist_len;
  // Expected beats still owed by the DUT and their unconsumed lanes
  beat_result_t exp_res [$];
  logic [7:0]   exp_mask [$];

  sme_top u_sme_top (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > CYCLE_LIMIT) abort_run("Simulation ran past its cycle limit");
  end

  //////////////////////////////
  // Reporting
  //////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "Stopping after the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
      abort_run($sformatf("mismatch at %0d ns: %s got %0h expected %0h", $time, name, got, exp));
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic rule_id_t table_id(input logic [23:0] win);
    case (win)
      `SME_PAT0: return `SME_ID0;
      `SME_PAT1: return `SME_ID1;
      `SME_PAT2: return `SME_ID2;
      `SME_PAT3: return `SME_ID3;
      default:   return '0;
    endcase
  endfunction

  function automatic int lowest_lane(input logic [7:0] m);
    for (int k = 0; k < 8; k++) begin
      if (m[k]) return k;
    end
    return 0;
  endfunction

  function automatic logic [63:0] model_state();
    logic [63:0] s;
    s = '0;
    for (int i = 0; i < 7; i++) s[8 + 8*i +: 8] = hist[i];
    s[3:0] = 4'(hist_len);
    return s;
  endfunction

  task automatic load_history(input logic [63:0] pre);
    for (int i = 0; i < 7; i++) hist[i] = pre[8 + 8*i +: 8];
    hist_len = (pre[7:0] > 8'd7) ? 7 : int'(pre[7:0]);
    exp_res.delete();
    exp_mask.delete();
  endtask

  task automatic apply_beat(input logic [63:0] data, input int len, input bit last);
    logic [7:0]   ext [15];
    beat_result_t r;
    logic [7:0]   m;
    for (int i = 0; i < 7; i++) ext[i] = hist[i];
    for (int k = 0; k < 8; k++) ext[7 + k] = data[8*k +: 8];
    r = '0;
    m = '0;
    // Window for lane k ends at beat byte k with the earliest byte low
    for (int k = 0; k < len; k++) begin
      if (hist_len + k + 1 >= 3) begin
        r.id[k] = table_id({ext[7 + k], ext[6 + k], ext[5 + k]});
        m[k]    = (r.id[k] != '0);
      end
    end
    if (m != '0) begin
      exp_res.push_back(r);
      exp_mask.push_back(m);
    end
    if (last) begin
      for (int i = 0; i < 7; i++) hist[i] = 8'h00;
      hist_len = 0;
    end else begin
      for (int i = 0; i < 7; i++) hist[i] = ext[len + i];
      hist_len = (hist_len + len > 7) ? 7 : hist_len + len;
    end
  endtask

  task automatic consume_front();
    exp_mask[0][lowest_lane(exp_mask[0])] = 1'b0;
    if (exp_mask[0] == '0) begin
      void'(exp_res.pop_front());
      void'(exp_mask.pop_front());
    end
  endtask

  task automatic check_outputs();
    check_value("last_bytes_state", last_bytes_state, model_state());
    if (match_valid) begin
      if (exp_mask.size() == 0) abort_run("match_valid is high but no result is expected");
      else begin
        check_value("match_index", match_index, exp_res[0].id[lowest_lane(exp_mask[0])]);
        check_value("match_valid_stat", match_valid_stat, exp_mask[0]);
      end
    end else begin
      check_value("match_valid_stat", match_valid_stat, 64'd0);
    end
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // One clock of stimulus that the model applies ahead of the rising edge
  task automatic drive_cycle(input bit valid, input logic [63:0] data, input int len,
                             input bit last, input bit rld, input logic [63:0] pre,
                             output bit took);
    bit nxt;
    @(negedge clk);
    check_outputs();
    nxt = !hold_next && (($random(seed) & 1) != 0);
    s_axis_tdata   = data;
    s_axis_tkeep   = 8'((16'd1 << len) - 16'd1);
    s_axis_tvalid  = valid;
    s_axis_tlast   = last;
    next_index     = nxt;
    reload         = rld;
    preamble_state = pre;
    #1;
    took = valid && s_axis_tready;
    if (rld) load_history(pre);
    else begin
      if (match_valid && nxt) consume_front();
      if (took) apply_beat(data, len, last);
    end
  endtask

  task automatic send_beat(input logic [63:0] data, input int len, input bit last);
    bit took;
    took = 1'b0;
    while (!took) drive_cycle(1'b1, data, len, last, 1'b0, '0, took);
  endtask

  task automatic reload_with(input logic [63:0] pre);
    bit took;
    drive_cycle(1'b0, '0, 0, 1'b0, 1'b1, pre, took);
    drive_cycle(1'b0, '0, 0, 1'b0, 1'b0, pre, took);
    check_value("last_bytes_state", last_bytes_state, pre);
  endtask

  // Repeating one beat keeps the stream data stable across a stall
  task automatic stall_test();
    bit took;
    int stalls;
    stalls = 0;
    hold_next = 1'b1;
    repeat (24) begin
      drive_cycle(1'b1, 64'h4241_4342_4143_4241, 8, 1'b0, 1'b0, '0, took);
      if (!took) stalls++;
    end
    hold_next = 1'b0;
    if (stalls == 0) abort_run("s_axis_tready never fell while next_index was held low");
  endtask

  function automatic logic [63:0] random_bytes();
    logic [63:0] d;
    for (int k = 0; k < 8; k++) d[8*k +: 8] = 8'h41 + 8'($random(seed) & 3);
    return d;
  endfunction

  initial begin
    logic [63:0] pre;
    bit          took;
    rst = 1'b1;
    s_axis_tdata = '0;
    s_axis_tkeep = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tlast = 1'b0;
    preamble_state = '0;
    reload = 1'b0;
    next_index = 1'b0;
    hold_next = 1'b0;
    for (int i = 0; i < 7; i++) hist[i] = 8'h00;
    hist_len = 0;
    repeat (8) @(negedge clk);
    check_value("s_axis_tready", s_axis_tready, 64'd0);
    check_value("match_valid", match_valid, 64'd0);
    rst = 1'b0;

    // DDA inside a beat and ABC across the boundary before tlast cuts the history
    send_beat(64'h4241_4444_4444_4444, 8, 1'b0);
    send_beat(64'h43, 1, 1'b0);
    send_beat(64'h4241_4444_4444_4444, 8, 1'b1);
    send_beat(64'h43, 1, 1'b1);

    // Reload drops pending hits before ABC straddles preamble and beat
    hold_next = 1'b1;
    send_beat(64'h4241_4342_4143_4241, 8, 1'b0);
    send_beat(64'h4241_4342_4143_4241, 8, 1'b0);
    reload_with(64'h4241_0000_0000_0002);
    hold_next = 1'b0;
    send_beat(64'h43, 1, 1'b0);

    stall_test();

    for (int b = 0; b < RANDOM_BEATS; b++) begin
      if ($unsigned($random(seed)) % 40 == 0) begin
        pre = random_bytes();
        pre[7:0] = 8'($unsigned($random(seed)) % 8);
        reload_with(pre);
      end
      repeat ($unsigned($random(seed)) % 3) drive_cycle(1'b0, '0, 0, 1'b0, 1'b0, '0, took);
      send_beat(random_bytes(), 1 + $unsigned($random(seed)) % 8,
                $unsigned($random(seed)) % 6 == 0);
    end

    for (int i = 0; i < 400 && exp_mask.size() != 0; i++)
      drive_cycle(1'b0, '0, 0, 1'b0, 1'b0, '0, took);
    repeat (10) drive_cycle(1'b0, '0, 0, 1'b0, 1'b0, '0, took);

    if (exp_mask.size() != 0) begin
      abort_run($sformatf("%0d expected results were never reported", exp_mask.size()));
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

// ==== tb.f ====
+incdir+include
logic/sme_pkg.sv
logic/lane_bus_if.sv
logic/window_feeder.sv
logic/pattern_lane.sv
logic/match_fifo.sv
logic/match_collector.sv
logic/sme_top.sv
sim/sme_tb.sv
